// File: rv_exec_alu.f
source/alu_pkg.sv
source/alu_operand_decode.sv
source/alu_int_unit.sv
source/alu_mul_unit.sv
source/alu_div_unit.sv
source/alu_result_ctrl.sv
source/alu_top.sv
verification/alu_tb.sv

// File: source/alu_div_unit.sv
`timescale 1ns/1ps

module alu_div_unit (
    input  logic                     clk,
    input  logic                     rst_n,
    input  logic                     start,
    input  logic                     abort,
    input  alu_pkg::alu_op_e         op,
    input  logic [alu_pkg::xlen-1:0] a,
    input  logic [alu_pkg::xlen-1:0] b,
    output logic                     done,
    output logic [alu_pkg::xlen-1:0] quotient_or_rem
);
    import alu_pkg::*;

    logic                 running;
    logic [div_cnt_w-1:0] step_cnt;
    logic                 launch;
    logic                 last_step;
    logic                 is_signed;
    logic [xlen-1:0]      abs_a;
    logic [xlen-1:0]      abs_b;
    logic                 want_rem;
    logic                 neg_q;
    logic                 neg_r;
    logic                 div_zero;
    logic                 overflow;
    logic [xlen-1:0]      dividend;
    logic [xlen-1:0]      divisor;
    logic [xlen-1:0]      quo;
    logic [xlen-1:0]      rem;
    logic [xlen:0]        rem_shift;
    logic [xlen:0]        diff;
    logic                 fits;
    logic [xlen-1:0]      q_fixed;
    logic [xlen-1:0]      r_fixed;

    assign launch    = start && !running;
    assign last_step = step_cnt == div_cnt_w'(div_steps - 1);
    assign is_signed = (op == op_div) || (op == op_rem);

    assign abs_a = (is_signed && a[xlen-1]) ? -a : a;
    assign abs_b = (is_signed && b[xlen-1]) ? -b : b;

    // one restoring step: shift in the next dividend bit, subtract if it fits
    assign rem_shift = {rem, quo[xlen-1]};
    assign diff      = rem_shift - {1'b0, divisor};
    assign fits      = rem_shift >= {1'b0, divisor};

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            running  <= 1'b0;
            step_cnt <= '0;
            done     <= 1'b0;
        end else if (abort) begin
            running  <= 1'b0;
            step_cnt <= '0;
            done     <= 1'b0;
        end else begin
            done <= 1'b0;
            if (launch) begin
                running  <= 1'b1;
                step_cnt <= '0;
            end else if (running) begin
                step_cnt <= step_cnt + 1'b1;
                if (last_step) begin
                    running <= 1'b0;
                    done    <= 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (launch) begin
            divisor  <= abs_b;
            quo      <= abs_a;
            rem      <= '0;
            dividend <= a;
            want_rem <= (op == op_rem) || (op == op_remu);
            neg_q    <= is_signed && (a[xlen-1] ^ b[xlen-1]);
            neg_r    <= is_signed && a[xlen-1];
            div_zero <= b == '0;
            overflow <= is_signed && (a == {1'b1, {(xlen-1){1'b0}}}) && (b == '1);
        end else if (running) begin
            rem <= fits ? diff[xlen-1:0] : rem_shift[xlen-1:0];
            quo <= {quo[xlen-2:0], fits};
        end
    end

    // remainder follows the dividend sign
    assign q_fixed = neg_q ? -quo : quo;
    assign r_fixed = neg_r ? -rem : rem;

    always_comb begin
        if (div_zero) begin
            quotient_or_rem = want_rem ? dividend : '1;
        end else if (overflow) begin
            quotient_or_rem = want_rem ? '0 : dividend;
        end else begin
            quotient_or_rem = want_rem ? r_fixed : q_fixed;
        end
    end

endmodule

// File: source/alu_int_unit.sv
`timescale 1ns/1ps

module alu_int_unit (
    input  alu_pkg::alu_operands_t      operands,
    output logic [alu_pkg::xlen-1:0]    int_result
);
    import alu_pkg::*;

    logic [xlen-1:0] a;
    logic [xlen-1:0] b;
    logic [5:0]      shamt;
    logic [31:0]     sra_word;
    logic [xlen-1:0] sra_full;
    logic            lt_signed;
    logic            lt_unsigned;

    assign a     = operands.a;
    assign b     = operands.b;
    assign shamt = b[5:0];

    // 32-bit arithmetic shift for word mode, upper half stays zero
    assign sra_word = $signed(a[31:0]) >>> shamt;
    assign sra_full = $signed(a) >>> shamt;

    assign lt_signed   = $signed(a) < $signed(b);
    assign lt_unsigned = a < b;

    always_comb begin
        case (operands.op)
            op_add:    int_result = a + b;
            op_sub:    int_result = a - b;
            op_pass_a: int_result = a;
            op_pass_b: int_result = b;
            op_xor:    int_result = a ^ b;
            op_or:     int_result = a | b;
            op_and:    int_result = a & b;
            op_sll:    int_result = a << shamt;
            op_srl:    int_result = a >> shamt;
            op_sra: begin
                if (operands.word) begin
                    int_result = {32'b0, sra_word};
                end else begin
                    int_result = sra_full;
                end
            end
            // comparisons give 1 or 0
            op_slt:    int_result = {{(xlen-1){1'b0}}, lt_signed};
            op_sltu:   int_result = {{(xlen-1){1'b0}}, lt_unsigned};
            op_eq:     int_result = {{(xlen-1){1'b0}}, a == b};
            op_ge:     int_result = {{(xlen-1){1'b0}}, ~lt_signed};
            op_geu:    int_result = {{(xlen-1){1'b0}}, ~lt_unsigned};
            // mul/div codes and unknown codes land here
            default:   int_result = '0;
        endcase
    end

endmodule

// File: source/alu_mul_unit.sv
`timescale 1ns/1ps

module alu_mul_unit (
    input  logic                     clk,
    input  logic                     rst_n,
    input  logic                     start,
    input  logic                     abort,
    input  logic [alu_pkg::xlen-1:0] a,
    input  logic [alu_pkg::xlen-1:0] b,
    output logic                     done,
    output logic [alu_pkg::xlen-1:0] product
);
    import alu_pkg::*;

    logic                 running;
    logic [mul_cnt_w-1:0] step_cnt;
    logic [xlen-1:0]      mcand;
    logic [xlen-1:0]      mplier;
    logic [xlen-1:0]      acc;
    logic [xlen-1:0]      partial;
    logic                 launch;
    logic                 last_step;

    assign launch    = start && !running;
    assign last_step = step_cnt == mul_cnt_w'(mul_steps - 1);

    // two multiplier bits per step, so 1x and 2x of the multiplicand
    assign partial = (mplier[0] ? mcand : '0) +
                     (mplier[1] ? {mcand[xlen-2:0], 1'b0} : '0);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            running  <= 1'b0;
            step_cnt <= '0;
            done     <= 1'b0;
        end else if (abort) begin
            running  <= 1'b0;
            step_cnt <= '0;
            done     <= 1'b0;
        end else begin
            done <= 1'b0;
            if (launch) begin
                running  <= 1'b1;
                step_cnt <= '0;
            end else if (running) begin
                step_cnt <= step_cnt + 1'b1;
                if (last_step) begin
                    running <= 1'b0;
                    done    <= 1'b1;
                end
            end
        end
    end

    // only the low xlen bits are kept, upper carries fall off
    always_ff @(posedge clk) begin
        if (launch) begin
            mcand  <= a;
            mplier <= b;
            acc    <= '0;
        end else if (running) begin
            acc    <= acc + partial;
            mcand  <= {mcand[xlen-3:0], 2'b00};
            mplier <= {2'b00, mplier[xlen-1:2]};
        end
    end

    assign product = acc;

endmodule

// File: source/alu_operand_decode.sv
`timescale 1ns/1ps

module alu_operand_decode (
    input  alu_pkg::alu_req_t      req,
    output alu_pkg::alu_operands_t operands
);
    import alu_pkg::*;

    logic [xlen-1:0] rs1_val;
    logic [xlen-1:0] a_val;
    logic [xlen-1:0] b_val;
    unit_e           unit_val;

    // word mode only narrows rs1, pc is left alone
    assign rs1_val = req.word ? {32'b0, req.rs1[31:0]} : req.rs1;

    always_comb begin
        if (req.sel_a == sel_a_rs1) begin
            a_val = rs1_val;
        end else begin
            a_val = req.pc;
        end
    end

    always_comb begin
        case (req.sel_b)
            sel_b_rs2: b_val = req.rs2;
            sel_b_csr: b_val = req.csr;
            default:   b_val = req.imm;
        endcase
    end

    // routing is decided here once
    always_comb begin
        case (req.op)
            op_mul:  unit_val = unit_mul;
            op_div,
            op_divu,
            op_rem,
            op_remu: unit_val = unit_div;
            default: unit_val = unit_int;
        endcase
    end

    always_comb begin
        operands.op   = req.op;
        operands.word = req.word;
        operands.unit = unit_val;
        operands.a    = a_val;
        operands.b    = b_val;
    end

endmodule

// File: source/alu_pkg.sv
package alu_pkg;

    // datapath width and iteration counts
    localparam int xlen      = 64;
    localparam int mul_steps = 32;
    localparam int div_steps = 64;

    // counter widths for the iterative units
    localparam int mul_cnt_w = $clog2(mul_steps);
    localparam int div_cnt_w = $clog2(div_steps);

    typedef enum logic [4:0] {
        op_add,
        op_sub,
        op_pass_a,
        op_pass_b,
        op_xor,
        op_or,
        op_and,
        op_sll,
        op_srl,
        op_sra,
        op_slt,
        op_sltu,
        op_eq,
        op_ge,
        op_geu,
        op_mul,
        op_div,
        op_divu,
        op_rem,
        op_remu
    } alu_op_e;

    typedef enum logic {
        sel_a_pc  = 1'b0,
        sel_a_rs1 = 1'b1
    } sel_a_e;

    typedef enum logic [1:0] {
        sel_b_imm = 2'd0,
        sel_b_rs2 = 2'd1,
        sel_b_csr = 2'd2
    } sel_b_e;

    typedef enum logic [1:0] {
        unit_int = 2'd0,
        unit_mul = 2'd1,
        unit_div = 2'd2
    } unit_e;

    // one request as it arrives from issue
    typedef struct packed {
        alu_op_e         op;
        sel_a_e          sel_a;
        sel_b_e          sel_b;
        logic            word;
        logic [xlen-1:0] pc;
        logic [xlen-1:0] rs1;
        logic [xlen-1:0] rs2;
        logic [xlen-1:0] csr;
        logic [xlen-1:0] imm;
    } alu_req_t;

    // request after operand selection
    typedef struct packed {
        alu_op_e         op;
        logic            word;
        unit_e           unit;
        logic [xlen-1:0] a;
        logic [xlen-1:0] b;
    } alu_operands_t;

endpackage

// File: source/alu_result_ctrl.sv
`timescale 1ns/1ps

module alu_result_ctrl (
    input  logic                     clk,
    input  logic                     rst_n,
    input  logic                     issue,
    input  logic                     flush,
    input  alu_pkg::unit_e           unit,
    input  logic [alu_pkg::xlen-1:0] int_result,
    input  logic                     mul_done,
    input  logic                     div_done,
    input  logic [alu_pkg::xlen-1:0] mul_product,
    input  logic [alu_pkg::xlen-1:0] div_value,
    output logic                     mul_start,
    output logic                     div_start,
    output logic                     abort,
    output logic [alu_pkg::xlen-1:0] result,
    output logic                     done,
    output logic                     busy
);
    import alu_pkg::*;

    logic accept;

    // issues during busy are dropped, flush cancels a same-cycle issue
    assign accept    = issue && !busy && !flush;
    assign mul_start = accept && (unit == unit_mul);
    assign div_start = accept && (unit == unit_div);
    assign abort     = flush;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            busy <= 1'b0;
        end else if (flush) begin
            busy <= 1'b0;
        end else if (mul_done || div_done) begin
            busy <= 1'b0;
        end else if (mul_start || div_start) begin
            busy <= 1'b1;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            done   <= 1'b0;
            result <= '0;
        end else begin
            done <= 1'b0;
            if (flush) begin
                done <= 1'b0;
            end else if (mul_done) begin
                result <= mul_product;
                done   <= 1'b1;
            end else if (div_done) begin
                result <= div_value;
                done   <= 1'b1;
            end else if (accept && (unit == unit_int)) begin
                result <= int_result;
                done   <= 1'b1;
            end
        end
    end

endmodule

// File: source/alu_top.sv
`timescale 1ns/1ps

module alu_top (
    input  logic                     clk,
    input  logic                     rst_n,
    input  logic                     issue,
    input  logic                     flush,
    input  alu_pkg::alu_req_t        req,
    output logic [alu_pkg::xlen-1:0] result,
    output logic                     done,
    output logic                     busy
);
    import alu_pkg::*;

    alu_operands_t   operands;
    logic [xlen-1:0] int_result;
    logic [xlen-1:0] mul_product;
    logic [xlen-1:0] div_value;
    logic            mul_start;
    logic            div_start;
    logic            mul_done;
    logic            div_done;
    logic            abort;

    alu_operand_decode u_decode (
        .req      (req),
        .operands (operands)
    );

    alu_int_unit u_int (
        .operands   (operands),
        .int_result (int_result)
    );

    alu_mul_unit u_mul (
        .clk     (clk),
        .rst_n   (rst_n),
        .start   (mul_start),
        .abort   (abort),
        .a       (operands.a),
        .b       (operands.b),
        .done    (mul_done),
        .product (mul_product)
    );

    alu_div_unit u_div (
        .clk             (clk),
        .rst_n           (rst_n),
        .start           (div_start),
        .abort           (abort),
        .op              (operands.op),
        .a               (operands.a),
        .b               (operands.b),
        .done            (div_done),
        .quotient_or_rem (div_value)
    );

    alu_result_ctrl u_ctrl (
        .clk         (clk),
        .rst_n       (rst_n),
        .issue       (issue),
        .flush       (flush),
        .unit        (operands.unit),
        .int_result  (int_result),
        .mul_done    (mul_done),
        .div_done    (div_done),
        .mul_product (mul_product),
        .div_value   (div_value),
        .mul_start   (mul_start),
        .div_start   (div_start),
        .abort       (abort),
        .result      (result),
        .done        (done),
        .busy        (busy)
    );

endmodule

// File: verification/alu_tb.sv
`timescale 1ns/1ps

module alu_tb;
    import alu_pkg::*;

    localparam logic [xlen-1:0] min_neg = {1'b1, {(xlen-1){1'b0}}};
    localparam int done_timeout = 100;

    logic            clk;
    logic            rst_n;
    logic            issue;
    logic            flush;
    alu_req_t        req;
    logic [xlen-1:0] result;
    logic            done;
    logic            busy;

    alu_top uut (
        .clk    (clk),
        .rst_n  (rst_n),
        .issue  (issue),
        .flush  (flush),
        .req    (req),
        .result (result),
        .done   (done),
        .busy   (busy)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    task automatic check_result(string name, logic [xlen-1:0] exp, logic [xlen-1:0] act);
        if (act !== exp) begin
            $display("Fail %s expected %h actual %h", name, exp, act);
            $display("TEST RESULT: FAIL");
            $fatal(1, "result mismatch");
        end
    endtask

    task automatic check_flag(string name, logic exp, logic act);
        if (act !== exp) begin
            $display("Fail %s expected %b actual %b", name, exp, act);
            $display("TEST RESULT: FAIL");
            $fatal(1, "flag mismatch");
        end
    endtask

    // edge values mixed in with plain random words
    function automatic logic [xlen-1:0] random_value();
        int pick;
        pick = $urandom_range(0, 7);
        case (pick)
            0: return '0;
            1: return '1;
            2: return min_neg;
            3: return xlen'($urandom_range(0, 70));
            default: return {$urandom(), $urandom()};
        endcase
    endfunction

    function automatic alu_req_t random_request(alu_op_e op);
        alu_req_t r;
        r.op    = op;
        r.sel_a = sel_a_e'($urandom_range(0, 1));
        r.sel_b = sel_b_e'($urandom_range(0, 2));
        r.word  = 1'($urandom_range(0, 1));
        r.pc    = random_value();
        r.rs1   = random_value();
        r.rs2   = random_value();
        r.csr   = random_value();
        r.imm   = random_value();
        return r;
    endfunction

    // reference model, straight from the ISA rules
    function automatic logic [xlen-1:0] expected_result(alu_req_t r);
        logic [xlen-1:0]    a;
        logic [xlen-1:0]    b;
        logic [5:0]         sh;
        logic signed [31:0] lo;
        logic               is_div;
        if (r.sel_a == sel_a_rs1) begin
            a = r.word ? {32'b0, r.rs1[31:0]} : r.rs1;
        end else begin
            a = r.pc;
        end
        case (r.sel_b)
            sel_b_rs2: b = r.rs2;
            sel_b_csr: b = r.csr;
            default:   b = r.imm;
        endcase
        sh     = b[5:0];
        is_div = (r.op == op_div) || (r.op == op_divu);
        // divide corner cases first
        if (r.op inside {op_div, op_divu, op_rem, op_remu}) begin
            if (b == '0) begin
                return is_div ? '1 : a;
            end
            if ((r.op == op_div || r.op == op_rem) && a == min_neg && b == '1) begin
                return (r.op == op_div) ? a : '0;
            end
        end
        case (r.op)
            op_add:    return a + b;
            op_sub:    return a - b;
            op_pass_a: return a;
            op_pass_b: return b;
            op_xor:    return a ^ b;
            op_or:     return a | b;
            op_and:    return a & b;
            op_sll:    return a << sh;
            op_srl:    return a >> sh;
            op_sra: begin
                if (r.word) begin
                    lo = a[31:0];
                    lo = lo >>> sh;
                    return {32'b0, lo};
                end
                return $signed(a) >>> sh;
            end
            op_slt:    return xlen'($signed(a) < $signed(b));
            op_sltu:   return xlen'(a < b);
            op_eq:     return xlen'(a == b);
            op_ge:     return xlen'($signed(a) >= $signed(b));
            op_geu:    return xlen'(a >= b);
            op_mul:    return a * b;
            op_div:    return $signed(a) / $signed(b);
            op_divu:   return a / b;
            op_rem:    return $signed(a) % $signed(b);
            op_remu:   return a % b;
            default:   return '0;
        endcase
    endfunction

    // called at a falling edge, returns one falling edge later
    task automatic issue_request(alu_req_t r);
        req   = r;
        issue = 1'b1;
        @(negedge clk);
        issue = 1'b0;
    endtask

    task automatic wait_for_done(string name, int limit);
        int cycles;
        cycles = 0;
        while (done !== 1'b1) begin
            @(negedge clk);
            cycles++;
            if (cycles > limit) begin
                $display("%s: done never arrived within %0d cycles", name, limit);
                $display("TEST RESULT: FAIL");
                $fatal(1, "timeout");
            end
        end
    endtask

    task automatic run_multi_cycle(alu_req_t r, string name);
        issue_request(r);
        check_flag({name, "_busy_high"}, 1'b1, busy);
        wait_for_done(name, done_timeout);
        check_flag({name, "_busy_low"}, 1'b0, busy);
        check_result(name, expected_result(r), result);
        @(negedge clk);
        check_flag({name, "_done_low"}, 1'b0, done);
    endtask

    initial begin
        alu_req_t r;
        alu_req_t r_next;
        int       done_count;
        void'($urandom(32'h9ecb_7f95));
        rst_n = 1'b0;
        issue = 1'b0;
        flush = 1'b0;
        req   = '0;
        repeat (4) @(negedge clk);
        rst_n = 1'b1;
        check_flag("reset_done", 1'b0, done);
        check_flag("reset_busy", 1'b0, busy);
        check_result("reset_result", '0, result);

        // single-cycle ops, done in the cycle right after the issue cycle
        for (int i = 0; i < 400; i++) begin
            r = random_request(alu_op_e'($urandom_range(0, 14)));
            issue_request(r);
            check_flag("int_busy", 1'b0, busy);
            check_flag("int_done", 1'b1, done);
            check_result({"int_", r.op.name()}, expected_result(r), result);
            @(negedge clk);
            check_flag("int_done_low", 1'b0, done);
        end

        for (int i = 0; i < 40; i++) begin
            run_multi_cycle(random_request(op_mul), "mul");
        end

        // zero divisor and signed overflow forced in every 16
        for (int i = 0; i < 80; i++) begin
            r = random_request(alu_op_e'(op_div + i % 4));
            if (i % 16 < 4) begin
                r.sel_b = sel_b_rs2;
                r.rs2   = '0;
            end else if (i % 16 < 8) begin
                r.sel_a = sel_a_rs1;
                r.word  = 1'b0;
                r.rs1   = min_neg;
                r.sel_b = sel_b_rs2;
                r.rs2   = '1;
            end
            run_multi_cycle(r, {"div_", r.op.name()});
        end

        for (int f = 0; f < 2; f++) begin
            issue_request(random_request(f == 0 ? op_mul : op_div));
            repeat (10) @(negedge clk);
            flush = 1'b1;
            @(negedge clk);
            flush = 1'b0;
            check_flag("flush_busy", 1'b0, busy);
            for (int c = 0; c < div_steps + 20; c++) begin
                check_flag("flush_no_done", 1'b0, done);
                @(negedge clk);
            end
            r = random_request(op_add);
            issue_request(r);
            check_flag("after_flush_done", 1'b1, done);
            check_result("after_flush", expected_result(r), result);
            @(negedge clk);
        end

        // second issue lands while the multiplier runs
        r      = random_request(op_mul);
        r_next = random_request(op_xor);
        issue_request(r);
        check_flag("busy_before_drop", 1'b1, busy);
        issue_request(r_next);
        done_count = 0;
        for (int c = 0; c < done_timeout; c++) begin
            if (done === 1'b1) begin
                done_count++;
                check_result("issue_while_busy", expected_result(r), result);
            end
            @(negedge clk);
        end
        check_result("done_pulse_count", 1, done_count);

        $display("TEST RESULT: PASS");
        $finish;
    end

endmodule
